/* hw/agu_credit_issue.sv */
`timescale 1ns/10ps
`default_nettype none

`include "agu_settings.svh"

// Credit based issue stage
// One beat per cycle while a run is active and credits remain
module agu_credit_issue import agu_pkg::*; (
    input  logic                   clk_i,
    input  logic                   reset_i,
    input  logic                   run_i,
    input  logic [`AGU_ADDR_W-1:0] addr_i,
    input  logic                   last_i,
    input  logic                   credit_i,
    output logic                   advance_o,
    output logic                   done_o,
    output logic                   beat_valid_o,
    output agu_beat_t              beat_o
);

    localparam int CRED_W = $clog2(`AGU_CREDITS + 1);

    logic [CRED_W-1:0] credit_q;
    logic              issue;
    logic              beat_valid_q;
    agu_beat_t         beat_q;

    // Issue decision for this cycle
    assign issue = run_i && (credit_q != '0);

    // Loop nest moves on the same edge that registers the beat
    assign advance_o = issue;

    // Run ends on the edge that registers the last beat
    assign done_o = issue && last_i;

    // Returned credit and issued beat in one cycle cancel out
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            credit_q <= CRED_W'(`AGU_CREDITS);
        end else if (credit_i && !issue) begin
            credit_q <= credit_q + 1'b1;
        end else if (!credit_i && issue) begin
            credit_q <= credit_q - 1'b1;
        end
    end

    // Valid flag
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            beat_valid_q <= 1'b0;
        end else begin
            beat_valid_q <= issue;
        end
    end

    // Beat payload, only loaded on issue
    always_ff @(posedge clk_i) begin
        if (issue) begin
            beat_q.addr <= addr_i;
            beat_q.last <= last_i;
        end
    end

    assign beat_valid_o = beat_valid_q;
    assign beat_o       = beat_q;

endmodule

`default_nettype wire

/* hw/agu_loop_nest.sv */
`timescale 1ns/10ps
`default_nettype none

`include "agu_settings.svh"

// Three nested loops built from step counters
// Address is base plus the sum of all loop counts
module agu_loop_nest import agu_pkg::*; (
    input  logic                   clk_i,
    input  logic                   reset_i,
    input  logic                   cfg_we_i,
    input  logic [1:0]             cfg_idx_i,
    input  agu_loop_cfg_t          cfg_i,
    input  logic                   start_i,
    input  logic [`AGU_ADDR_W-1:0] base_i,
    input  logic                   advance_i,
    output logic [`AGU_ADDR_W-1:0] addr_o,
    output logic                   last_o
);

    // Loop setup as written by the decoder
    agu_loop_cfg_t cfg_q [`AGU_LOOPS];

    // Run values latched at start
    logic [`AGU_ADDR_W-1:0] base_q;
    logic [`AGU_CNT_W-1:0]  max_q [`AGU_LOOPS];

    // Counter side
    logic [`AGU_CNT_W-1:0] count [`AGU_LOOPS];
    logic [`AGU_LOOPS-1:0] tc;
    logic [`AGU_LOOPS-1:0] en;

    // tc_chain[i] is high when every level below i is at its end
    logic [`AGU_LOOPS:0]    tc_chain;
    logic [`AGU_ADDR_W-1:0] sum;

    // Loop setup storage, indices past the last level are dropped
    always_ff @(posedge clk_i) begin
        if (cfg_we_i && (cfg_idx_i < 2'(`AGU_LOOPS))) begin
            cfg_q[cfg_idx_i] <= cfg_i;
        end
    end

    // At start each max becomes stride times (bound - 1)
    // A zero stride collapses its level to a single pass
    always_ff @(posedge clk_i) begin
        if (start_i) begin
            base_q <= base_i;
            for (int i = 0; i < `AGU_LOOPS; i++) begin
                // Bound 0 acts as bound 1
                if (cfg_q[i].bound == 12'd0) begin
                    max_q[i] <= '0;
                end else begin
                    max_q[i] <= `AGU_CNT_W'(cfg_q[i].stride * (cfg_q[i].bound - 12'd1));
                end
            end
        end
    end

    // Carry chain of terminal counts, innermost first
    always_comb begin
        tc_chain[0] = 1'b1;
        for (int i = 0; i < `AGU_LOOPS; i++) begin
            tc_chain[i+1] = tc_chain[i] & tc[i];
        end
    end

    // Outer levels step only when all inner levels wrap
    assign en = {`AGU_LOOPS{advance_i}} & tc_chain[`AGU_LOOPS-1:0];

    for (genvar gi = 0; gi < `AGU_LOOPS; gi++) begin : g_loop
        step_counter #(
            .WIDTH (`AGU_CNT_W)
        ) u_step_counter (
            .clk_i   (clk_i),
            .reset_i (reset_i),
            .clear_i (start_i),
            .en_i    (en[gi]),
            .step_i  (cfg_q[gi].stride),
            .init_i  ('0),
            .max_i   (max_q[gi]),
            .count_o (count[gi]),
            .tc_o    (tc[gi])
        );
    end

    // Sum of the loop offsets, modulo the address width
    always_comb begin
        sum = '0;
        for (int i = 0; i < `AGU_LOOPS; i++) begin
            sum = sum + `AGU_ADDR_W'(count[i]);
        end
    end

    assign addr_o = base_q + sum;

    // Final point once every level is at its end
    assign last_o = tc_chain[`AGU_LOOPS];

endmodule

`default_nettype wire

/* hw/agu_pkg.sv */
`default_nettype none

package agu_pkg;

    `include "agu_settings.svh"

    // Command opcodes, shared by both views of a command word
    typedef enum logic [1:0] {
        AGU_OP_LOOP = 2'd1,
        AGU_OP_BASE = 2'd2
    } agu_op_e;

    // Loop setup view
    typedef struct packed {
        agu_op_e                op;
        logic [1:0]             idx;
        logic [11:0]            bound;
        logic [`AGU_CNT_W-1:0]  stride;
    } agu_loop_cmd_t;

    // Base and start view, the reserved bits are ignored
    typedef struct packed {
        agu_op_e                op;
        logic [13:0]            rsvd;
        logic [`AGU_ADDR_W-1:0] base;
    } agu_base_cmd_t;

    // One 32-bit command word, decoded by its opcode
    typedef union packed {
        agu_loop_cmd_t loop_cmd;
        agu_base_cmd_t base_cmd;
    } agu_cmd_u;

    // Stored setup of one loop level
    typedef struct packed {
        logic [11:0]           bound;
        logic [`AGU_CNT_W-1:0] stride;
    } agu_loop_cfg_t;

    // Issued address, last marks the final address of a run
    typedef struct packed {
        logic [`AGU_ADDR_W-1:0] addr;
        logic                   last;
    } agu_beat_t;

endpackage

`default_nettype wire

/* hw/agu_top.sv */
`timescale 1ns/10ps
`default_nettype none

`include "agu_settings.svh"

// Strided address generator
// Decodes command words and drives the loop nest and issue stage
module agu_top import agu_pkg::*; (
    input  logic      clk_i,
    input  logic      reset_i,
    input  logic      cmd_valid_i,
    input  agu_cmd_u  cmd_i,
    input  logic      credit_i,
    output logic      beat_valid_o,
    output agu_beat_t beat_o,
    output logic      busy_o
);

    // Decoder outputs
    logic          accept;
    logic          cfg_we;
    logic [1:0]    cfg_idx;
    agu_loop_cfg_t cfg;
    logic          start;

    logic [`AGU_ADDR_W-1:0] base;

    // Loop nest to issue stage
    logic [`AGU_ADDR_W-1:0] addr;
    logic                   last;
    logic                   advance;
    logic                   done;

    logic busy_q;

    // Commands are only taken while idle
    assign accept = cmd_valid_i && !busy_q;

    // Loop setup view
    assign cfg_we     = accept && (cmd_i.loop_cmd.op == AGU_OP_LOOP);
    assign cfg_idx    = cmd_i.loop_cmd.idx;
    assign cfg.bound  = cmd_i.loop_cmd.bound;
    assign cfg.stride = cmd_i.loop_cmd.stride;

    // Base and start view
    assign start = accept && (cmd_i.base_cmd.op == AGU_OP_BASE);
    assign base  = cmd_i.base_cmd.base;

    // Busy from start until the last beat is registered
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            busy_q <= 1'b0;
        end else if (start) begin
            busy_q <= 1'b1;
        end else if (done) begin
            busy_q <= 1'b0;
        end
    end

    assign busy_o = busy_q;

    agu_loop_nest u_agu_loop_nest (
        .clk_i     (clk_i),
        .reset_i   (reset_i),
        .cfg_we_i  (cfg_we),
        .cfg_idx_i (cfg_idx),
        .cfg_i     (cfg),
        .start_i   (start),
        .base_i    (base),
        .advance_i (advance),
        .addr_o    (addr),
        .last_o    (last)
    );

    // Runs as long as busy is set
    agu_credit_issue u_agu_credit_issue (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .run_i        (busy_q),
        .addr_i       (addr),
        .last_i       (last),
        .credit_i     (credit_i),
        .advance_o    (advance),
        .done_o       (done),
        .beat_valid_o (beat_valid_o),
        .beat_o       (beat_o)
    );

endmodule

`default_nettype wire

/* hw/step_counter.sv */
`timescale 1ns/10ps
`default_nettype none

// Counter that adds a fixed step per enabled cycle
// and wraps back to its init value once it sits at max
module step_counter #(
    parameter int WIDTH = 8
) (
    input  logic             clk_i,
    input  logic             reset_i,
    input  logic             clear_i,
    input  logic             en_i,
    input  logic [WIDTH-1:0] step_i,
    input  logic [WIDTH-1:0] init_i,
    input  logic [WIDTH-1:0] max_i,
    output logic [WIDTH-1:0] count_o,
    output logic             tc_o
);

    logic [WIDTH-1:0] count_q;
    logic [WIDTH-1:0] count_d;

    // Next value while enabled
    always_comb begin
        if (tc_o) begin
            // Wrap to the start of the range
            count_d = init_i;
        end else begin
            count_d = count_q + step_i;
        end
    end

    // Reset and clear both restart from init
    always_ff @(posedge clk_i) begin
        if (reset_i || clear_i) begin
            count_q <= init_i;
        end else if (en_i) begin
            count_q <= count_d;
        end
    end

    // Terminal count straight from the stored value
    assign tc_o    = (count_q == max_i);
    assign count_o = count_q;

endmodule

`default_nettype wire

/* include/agu_settings.svh */
`ifndef AGU_SETTINGS_SVH
`define AGU_SETTINGS_SVH

// Width of issued addresses and of the base register
`define AGU_ADDR_W 16

// Width of each loop step counter, also the stride width
`define AGU_CNT_W 16

// Number of nested loop levels, innermost is level 0
`define AGU_LOOPS 3

// Credits the consumer grants after reset
`define AGU_CREDITS 4

`endif

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1

if ! command -v verilator >/dev/null 2>&1; then
    echo "verilator is not installed or not on the PATH"
    exit 1
fi

verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module agu_tb -o agu_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/agu_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

# Result comes from the testbench's own pass line
if printf '%s\n' "$output" | grep -qx "TEST OK"; then
    exit 0
fi
exit 1

/* sim.f */
+incdir+include
hw/agu_pkg.sv
hw/step_counter.sv
hw/agu_loop_nest.sv
hw/agu_credit_issue.sv
hw/agu_top.sv
test/agu_assertions.sv
test/agu_tb.sv

/* test/agu_assertions.sv */
`timescale 1ns/10ps
`default_nettype none

`include "agu_settings.svh"

// Credit accounting checks bound into the issue stage
module agu_assertions #(
    parameter int CRED_W = $clog2(`AGU_CREDITS + 1)
) (
    input  logic              clk_i,
    input  logic              reset_i,
    input  logic [CRED_W-1:0] credit_q_i,
    input  logic              beat_valid_i
);

    // Count never goes past the credits granted at reset
    credit_limit_a: assert property (
        @(posedge clk_i) disable iff (reset_i)
        credit_q_i <= CRED_W'(`AGU_CREDITS)
    ) else $error("credit count above the granted limit");

    // No beat leaves the stage one edge after an empty count
    issue_credit_a: assert property (
        @(posedge clk_i) disable iff (reset_i)
        (credit_q_i == '0) |=> !beat_valid_i
    ) else $error("beat issued with zero credits");

    // Valid is cleared by reset
    reset_valid_a: assert property (
        @(posedge clk_i)
        reset_i |=> !beat_valid_i
    ) else $error("beat valid high during reset");

endmodule

`default_nettype wire

/* test/agu_patterns.txt */
// One test per row, all values hex, loop 0 is the innermost
// base bound0 bound1 bound2 stride0 stride1 stride2 rate% hold count sum last
1000 4 3 2 1    10 100  64 0  18 18da4 1123
0200 5 1 1 4    8  8    32 c  5  a28   210
3000 3 4 2 2    0  40   19 0  6  120cc 3044
beef 1 1 1 1    1  1    64 0  1  beef  beef
fff0 8 2 1 4    20 0    50 6  10 400e0 2c
0000 6 5 4 3    20 400  28 0  78 2f184 c8f
0800 1 1 7 5    5  11   0a 14 7  3965  866
0100 3 2 2 ffff 8  1000 64 8  c  6c24  1106

/* test/agu_tb.sv */
`timescale 1ns/10ps
`default_nettype none

`include "agu_settings.svh"

module agu_tb import agu_pkg::*; ();

    localparam int NUM_TESTS = 8;
    localparam int FIELDS    = 12;

    logic      clk;
    logic      reset;
    logic      cmd_valid;
    agu_cmd_u  cmd;
    logic      credit;
    logic      beat_valid;
    agu_beat_t beat;
    logic      busy;

    // Rows of the pattern file with FIELDS words each
    logic [31:0] pat_mem [NUM_TESTS*FIELDS];

    // Addresses the model expects for the current run
    logic [`AGU_ADDR_W-1:0] exp_q [$];

    int errors;
    int test_errors;
    int failed_tests;
    int limit_cycles;

    agu_top u_agu_top (
        .clk_i        (clk),
        .reset_i      (reset),
        .cmd_valid_i  (cmd_valid),
        .cmd_i        (cmd),
        .credit_i     (credit),
        .beat_valid_o (beat_valid),
        .beat_o       (beat),
        .busy_o       (busy)
    );

    bind agu_credit_issue agu_assertions u_agu_assertions (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .credit_q_i   (credit_q),
        .beat_valid_i (beat_valid_o)
    );

    // 4 ns period
    always #2 clk = ~clk;

    function automatic logic [31:0] pattern_field(int t, int f);
        return pat_mem[t*FIELDS+f];
    endfunction

    // A level with stride 0 has max 0, so it collapses to one pass
    function automatic int loop_span(logic [31:0] bound, logic [31:0] stride);
        if (bound == 0 || stride == 0) begin
            return 1;
        end
        return int'(bound);
    endfunction

    function automatic agu_cmd_u make_loop_cmd(int idx, logic [31:0] bound, logic [31:0] stride);
        agu_cmd_u c;
        c.loop_cmd.op     = AGU_OP_LOOP;
        c.loop_cmd.idx    = 2'(idx);
        c.loop_cmd.bound  = 12'(bound);
        c.loop_cmd.stride = 16'(stride);
        return c;
    endfunction

    function automatic agu_cmd_u make_base_cmd(logic [31:0] base);
        agu_cmd_u c;
        c.base_cmd.op   = AGU_OP_BASE;
        c.base_cmd.rsvd = '0;
        c.base_cmd.base = 16'(base);
        return c;
    endfunction

    task automatic report_error(input string msg);
        $display("** Error at %0t: %s", $time, msg);
        test_errors++;
    endtask

    // Nested loops with the innermost fastest and addresses modulo their width
    task automatic build_model(input int t);
        int          n0;
        int          n1;
        int          n2;
        logic [31:0] sum;
        n0 = loop_span(pattern_field(t, 1), pattern_field(t, 4));
        n1 = loop_span(pattern_field(t, 2), pattern_field(t, 5));
        n2 = loop_span(pattern_field(t, 3), pattern_field(t, 6));
        exp_q.delete();
        for (int k2 = 0; k2 < n2; k2++) begin
            for (int k1 = 0; k1 < n1; k1++) begin
                for (int k0 = 0; k0 < n0; k0++) begin
                    exp_q.push_back(`AGU_ADDR_W'(pattern_field(t, 0) + k0 * pattern_field(t, 4)
                        + k1 * pattern_field(t, 5) + k2 * pattern_field(t, 6)));
                end
            end
        end
        sum = 0;
        foreach (exp_q[i]) begin
            sum = sum + 32'(exp_q[i]);
        end
        // Model against the values written in the pattern row
        if (exp_q.size() != int'(pattern_field(t, 9))) begin
            report_error($sformatf("model count %0d, pattern count %0d",
                exp_q.size(), pattern_field(t, 9)));
        end
        if (sum != pattern_field(t, 10)) begin
            report_error($sformatf("model sum %h, pattern sum %h", sum, pattern_field(t, 10)));
        end
        if (32'(exp_q[$]) != pattern_field(t, 11)) begin
            report_error($sformatf("model last %h, pattern last %h",
                exp_q[$], pattern_field(t, 11)));
        end
    endtask

    task automatic send_cmd(input agu_cmd_u c);
        @(negedge clk);
        cmd_valid = 1'b1;
        cmd       = c;
    endtask

    task automatic run_test(input int t);
        int   n;
        int   got;
        int   pending;
        int   hold_left;
        int   rate;
        logic injected;
        logic is_final;
        test_errors = 0;
        build_model(t);
        n         = exp_q.size();
        rate      = int'(pattern_field(t, 7));
        hold_left = int'(pattern_field(t, 8));
        for (int i = 0; i < `AGU_LOOPS; i++) begin
            send_cmd(make_loop_cmd(i, pattern_field(t, 1 + i), pattern_field(t, 4 + i)));
        end
        send_cmd(make_base_cmd(pattern_field(t, 0)));
        got      = 0;
        pending  = 0;
        injected = 1'b0;
        while (got < n) begin
            @(negedge clk);
            cmd_valid = 1'b0;
            credit    = 1'b0;
            if (beat_valid) begin
                is_final = (got == n - 1);
                if (beat.addr != exp_q[got]) begin
                    report_error($sformatf("beat %0d addr %h, expected %h",
                        got, beat.addr, exp_q[got]));
                end
                if (beat.last != is_final) begin
                    report_error($sformatf("beat %0d last %b, expected %b",
                        got, beat.last, is_final));
                end
                if (busy == is_final) begin
                    report_error($sformatf("beat %0d busy %b, expected %b",
                        got, busy, !is_final));
                end
                got++;
                pending++;
            end
            // Mid-run command that alternates between a loop setup and a new start
            if (!injected && busy && got > 0) begin
                cmd_valid = 1'b1;
                cmd       = (t % 2 == 0) ? make_loop_cmd(0, 1, 0) :
                                           make_base_cmd(~pattern_field(t, 0));
                injected  = 1'b1;
            end
            // While credits are withheld the DUT must stop at the granted amount
            if (hold_left > 0) begin
                hold_left--;
                if (got > `AGU_CREDITS) begin
                    report_error($sformatf("%0d beats issued without any credit", got));
                end
            end else if (pending > 0 && ($urandom % 100) < rate) begin
                credit = 1'b1;
                pending--;
            end
        end
        // Return what is left and expect silence
        repeat (pending + 2) begin
            @(negedge clk);
            cmd_valid = 1'b0;
            credit    = (pending > 0);
            if (pending > 0) begin
                pending--;
            end
            if (beat_valid) begin
                report_error("beat issued after the last one");
            end
            if (busy) begin
                report_error("busy still set after the run");
            end
        end
        credit = 1'b0;
        $display("test %0d: %0d beats, %0d errors", t, got, test_errors);
        errors += test_errors;
        if (test_errors != 0) begin
            failed_tests++;
        end
    endtask

    // Ends the run if the DUT stops issuing
    initial begin
        wait (limit_cycles != 0);
        repeat (limit_cycles) @(posedge clk);
        $display("Timeout after %0d cycles, the run did not finish", limit_cycles);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        int limit;
        clk          = 1'b0;
        reset        = 1'b1;
        cmd_valid    = 1'b0;
        cmd          = '0;
        credit       = 1'b0;
        errors       = 0;
        failed_tests = 0;
        limit_cycles = 0;
        void'($urandom(32'h36f6));
        $readmemh("test/agu_patterns.txt", pat_mem);
        // 20 cycles per loop point plus hold time and a margin
        limit = 100 * NUM_TESTS;
        for (int t = 0; t < NUM_TESTS; t++) begin
            limit += 20 * int'(pattern_field(t, 1) * pattern_field(t, 2) * pattern_field(t, 3));
            limit += int'(pattern_field(t, 8));
        end
        limit_cycles = limit;
        repeat (8) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        test_errors = 0;
        if (beat_valid !== 1'b0) begin
            report_error("beat valid not low after reset");
        end
        if (busy !== 1'b0) begin
            report_error("busy not low after reset");
        end
        $display("reset check: %0d errors", test_errors);
        errors += test_errors;
        for (int t = 0; t < NUM_TESTS; t++) begin
            run_test(t);
        end
        $display("tests %0d, failed %0d, errors %0d", NUM_TESTS, failed_tests, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
